//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_banked_sram
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation finished: PASS

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

# The run fails unless the pass message appears in the simulator output
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- list.f
src/bank_ram_pkg.sv
src/write_queue.sv
src/bank_arbiter.sv
src/bank_array.sv
src/banked_sram.sv
tests/sram_checker.sv
tests/tb_banked_sram.sv

//--- src/bank_arbiter.sv
`timescale 1ns/1ps

module bank_arbiter
(
    input  logic                                  clk,
    input  logic                                  reset,
    input  bank_ram_pkg::queue_entry_t            heads [bank_ram_pkg::NUM_PORTS],
    input  logic [bank_ram_pkg::NUM_PORTS-1:0]    empty,
    output logic [bank_ram_pkg::NUM_PORTS-1:0]    pop,
    output bank_ram_pkg::bank_wr_t                bank_wr [bank_ram_pkg::NUM_BANKS],
    output logic                                  pending
);

    // One-hot port grant for each bank
    logic [bank_ram_pkg::NUM_PORTS-1:0] grant [bank_ram_pkg::NUM_BANKS];

    bank_ram_pkg::row_t                 win_row  [bank_ram_pkg::NUM_BANKS];
    bank_ram_pkg::data_t                win_data [bank_ram_pkg::NUM_BANKS];

    logic [bank_ram_pkg::NUM_BANKS-1:0] wr_valid;
    bank_ram_pkg::row_t                 wr_row   [bank_ram_pkg::NUM_BANKS];
    bank_ram_pkg::data_t                wr_data  [bank_ram_pkg::NUM_BANKS];

    ////////////////////////////////////////////////////////////
    // Fixed-priority grant per bank
    ////////////////////////////////////////////////////////////

    // Lowest-numbered port with a head for this bank wins
    always_comb
    begin
        for (int b = 0; b < bank_ram_pkg::NUM_BANKS; b++)
        begin
            grant[b] = '0;
            for (int p = 0; p < bank_ram_pkg::NUM_PORTS; p++)
            begin
                if (!empty[p] && heads[p].bank == bank_ram_pkg::bank_idx_t'(b)
                    && grant[b] == '0)
                    grant[b][p] = 1'b1;
            end
        end
    end

    // A head targets one bank only, so a port is granted at most once
    always_comb
    begin
        pop = '0;
        for (int b = 0; b < bank_ram_pkg::NUM_BANKS; b++)
            pop = pop | grant[b];
    end

    // Winner payload
    always_comb
    begin
        for (int b = 0; b < bank_ram_pkg::NUM_BANKS; b++)
        begin
            win_row[b]  = '0;
            win_data[b] = '0;
            for (int p = 0; p < bank_ram_pkg::NUM_PORTS; p++)
            begin
                if (grant[b][p])
                begin
                    win_row[b]  = heads[p].row;
                    win_data[b] = heads[p].data;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Registered bank writes
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            wr_valid <= '0;
        else
            for (int b = 0; b < bank_ram_pkg::NUM_BANKS; b++)
                wr_valid[b] <= |grant[b];
    end

    always_ff @(posedge clk)
    begin
        for (int b = 0; b < bank_ram_pkg::NUM_BANKS; b++)
        begin
            if (|grant[b])
            begin
                wr_row[b]  <= win_row[b];
                wr_data[b] <= win_data[b];
            end
        end
    end

    always_comb
    begin
        for (int b = 0; b < bank_ram_pkg::NUM_BANKS; b++)
        begin
            bank_wr[b].valid = wr_valid[b];
            bank_wr[b].row   = wr_row[b];
            bank_wr[b].data  = wr_data[b];
        end
    end

    // Writes still queued or on their way into the array
    assign pending = !(&empty) || (|wr_valid);

endmodule

//--- src/bank_array.sv
`timescale 1ns/1ps

module bank_array
(
    input  logic                       clk,
    input  bank_ram_pkg::bank_wr_t     bank_wr [bank_ram_pkg::NUM_BANKS],
    input  bank_ram_pkg::word_addr_t   rd_addr [bank_ram_pkg::NUM_PORTS],
    output bank_ram_pkg::data_t        rd_data [bank_ram_pkg::NUM_PORTS]
);

    // Bank b holds word addresses b, b+4, b+8 and so on
    bank_ram_pkg::data_t mem [bank_ram_pkg::NUM_BANKS][2**bank_ram_pkg::ROW_BITS];

    bank_ram_pkg::bank_idx_t rd_bank [bank_ram_pkg::NUM_PORTS];
    bank_ram_pkg::row_t      rd_row  [bank_ram_pkg::NUM_PORTS];

    ////////////////////////////////////////////////////////////
    // Write side
    ////////////////////////////////////////////////////////////

    // One write per bank per cycle at most
    always_ff @(posedge clk)
    begin
        for (int b = 0; b < bank_ram_pkg::NUM_BANKS; b++)
        begin
            if (bank_wr[b].valid)
                mem[b][bank_wr[b].row] <= bank_wr[b].data;
        end
    end

    ////////////////////////////////////////////////////////////
    // Read muxes
    ////////////////////////////////////////////////////////////

    // Address split for each read port
    always_comb
    begin
        for (int p = 0; p < bank_ram_pkg::NUM_PORTS; p++)
        begin
            rd_bank[p] = rd_addr[p][bank_ram_pkg::BANK_BITS-1:0];
            rd_row[p]  = rd_addr[p][bank_ram_pkg::ADDR_BITS-1:bank_ram_pkg::BANK_BITS];
        end
    end

    // No forwarding from queued writes
    always_comb
    begin
        for (int p = 0; p < bank_ram_pkg::NUM_PORTS; p++)
            rd_data[p] = mem[rd_bank[p]][rd_row[p]];
    end

endmodule

//--- src/bank_ram_pkg.sv
package bank_ram_pkg;

    ////////////////////////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////////////////////////

    localparam int NUM_PORTS     = 4;
    localparam int NUM_BANKS     = 4;
    localparam int BANK_BITS     = 2;
    localparam int ROW_BITS      = 9;
    localparam int ADDR_BITS     = BANK_BITS + ROW_BITS;
    localparam int DATA_BITS     = 32;

    // Per-port write queue
    localparam int FIFO_DEPTH    = 4;
    localparam int FIFO_PTR_BITS = 2;

    ////////////////////////////////////////////////////////////
    // Field types and structs
    ////////////////////////////////////////////////////////////

    typedef logic [ADDR_BITS-1:0] word_addr_t;
    typedef logic [DATA_BITS-1:0] data_t;
    typedef logic [BANK_BITS-1:0] bank_idx_t;
    typedef logic [ROW_BITS-1:0]  row_t;

    // Raw write strobe from one port
    typedef struct packed {
        logic       we;
        word_addr_t addr;
        data_t      data;
    } wr_req_t;

    // Write after the address split
    typedef struct packed {
        bank_idx_t bank;
        row_t      row;
        data_t     data;
    } queue_entry_t;

    // One registered write into a bank
    typedef struct packed {
        logic  valid;
        row_t  row;
        data_t data;
    } bank_wr_t;

endpackage

//--- src/banked_sram.sv
`timescale 1ns/1ps

module banked_sram
(
    input  logic                               clk,
    input  logic                               reset,
    input  bank_ram_pkg::wr_req_t              wr_req  [bank_ram_pkg::NUM_PORTS],
    input  bank_ram_pkg::word_addr_t           rd_addr [bank_ram_pkg::NUM_PORTS],
    output bank_ram_pkg::data_t                rd_data [bank_ram_pkg::NUM_PORTS],
    output logic [bank_ram_pkg::NUM_PORTS-1:0] full,
    output logic                               pending
);

    // Queue heads and handshake toward the arbiter
    bank_ram_pkg::queue_entry_t         q_head [bank_ram_pkg::NUM_PORTS];
    logic [bank_ram_pkg::NUM_PORTS-1:0] q_empty;
    logic [bank_ram_pkg::NUM_PORTS-1:0] q_pop;

    // Registered writes into the banks
    bank_ram_pkg::bank_wr_t             bank_wr [bank_ram_pkg::NUM_BANKS];

    ////////////////////////////////////////////////////////////
    // Per-port write queues
    ////////////////////////////////////////////////////////////

    genvar i;
    generate
        for (i = 0; i < bank_ram_pkg::NUM_PORTS; i++)
        begin : g_queue
            write_queue u_queue
            (
                .clk   (clk),
                .reset (reset),
                .req   (wr_req[i]),
                .pop   (q_pop[i]),
                .head  (q_head[i]),
                .empty (q_empty[i]),
                .full  (full[i])
            );
        end
    endgenerate

    ////////////////////////////////////////////////////////////
    // Arbitration and storage
    ////////////////////////////////////////////////////////////

    bank_arbiter u_arbiter
    (
        .clk     (clk),
        .reset   (reset),
        .heads   (q_head),
        .empty   (q_empty),
        .pop     (q_pop),
        .bank_wr (bank_wr),
        .pending (pending)
    );

    // Combinational reads from the banks
    bank_array u_array
    (
        .clk     (clk),
        .bank_wr (bank_wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

//--- src/write_queue.sv
`timescale 1ns/1ps

module write_queue
(
    input  logic                       clk,
    input  logic                       reset,
    input  bank_ram_pkg::wr_req_t      req,
    input  logic                       pop,
    output bank_ram_pkg::queue_entry_t head,
    output logic                       empty,
    output logic                       full
);

    bank_ram_pkg::queue_entry_t             entries [bank_ram_pkg::FIFO_DEPTH];
    logic [bank_ram_pkg::FIFO_PTR_BITS-1:0] wr_ptr;
    logic [bank_ram_pkg::FIFO_PTR_BITS-1:0] rd_ptr;
    logic [bank_ram_pkg::FIFO_PTR_BITS:0]   count;
    bank_ram_pkg::queue_entry_t             decoded;
    logic                                   push;
    logic                                   do_pop;

    ////////////////////////////////////////////////////////////
    // Address split on entry
    ////////////////////////////////////////////////////////////

    // Low bits pick the bank, the rest is the row
    always_comb
    begin
        decoded.bank = req.addr[bank_ram_pkg::BANK_BITS-1:0];
        decoded.row  = req.addr[bank_ram_pkg::ADDR_BITS-1:bank_ram_pkg::BANK_BITS];
        decoded.data = req.data;
    end

    // Strobe while full is lost
    assign push   = req.we && !full;
    assign do_pop = pop && !empty;

    assign full  = (count == (bank_ram_pkg::FIFO_PTR_BITS + 1)'(bank_ram_pkg::FIFO_DEPTH));
    assign empty = (count == '0);
    assign head  = entries[rd_ptr];

    ////////////////////////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////////////////////////

    // Pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Entry storage
    always_ff @(posedge clk)
    begin
        if (push)
            entries[wr_ptr] <= decoded;
    end

endmodule

//--- tests/sram_checker.sv
`timescale 1ns/1ps

module sram_checker
(
    input  logic                               clk,
    input  logic                               reset,
    input  bank_ram_pkg::wr_req_t              wr_req  [bank_ram_pkg::NUM_PORTS],
    input  logic [bank_ram_pkg::NUM_PORTS-1:0] full,
    input  logic [bank_ram_pkg::NUM_PORTS-1:0] expect_room,
    input  bank_ram_pkg::word_addr_t           rd_addr [bank_ram_pkg::NUM_PORTS],
    input  bank_ram_pkg::data_t                rd_data [bank_ram_pkg::NUM_PORTS],
    input  logic                               pending,
    input  logic                               check_en,
    output int                                 value_errors,
    output int                                 drop_errors,
    output int                                 read_checks
);

    localparam int NUM_WORDS = 2**bank_ram_pkg::ADDR_BITS;

    // Flat reference memory over the whole word address space
    bank_ram_pkg::data_t ref_mem     [NUM_WORDS];
    logic                ref_written [NUM_WORDS];

    function automatic bank_ram_pkg::data_t expected_word(input bank_ram_pkg::word_addr_t addr);
        return ref_mem[addr];
    endfunction

    initial
    begin
        value_errors = 0;
        drop_errors  = 0;
        read_checks  = 0;
        for (int a = 0; a < NUM_WORDS; a++)
            ref_written[a] = 1'b0;
    end

    ////////////////////////////////////////////////////////////
    // Compare reads, then track accepted writes
    ////////////////////////////////////////////////////////////

    always @(posedge clk)
    begin
        if (!reset)
        begin
            // Only once every posted write has landed
            if (check_en && !pending)
            begin
                for (int p = 0; p < bank_ram_pkg::NUM_PORTS; p++)
                begin
                    if (ref_written[rd_addr[p]])
                    begin
                        read_checks++;
                        if (rd_data[p] !== expected_word(rd_addr[p]))
                        begin
                            value_errors++;
                            $display("[FAIL] rd_data[%0d] addr 0x%h expected 0x%h actual 0x%h",
                                     p, rd_addr[p], expected_word(rd_addr[p]), rd_data[p]);
                        end
                    end
                end
            end

            for (int p = 0; p < bank_ram_pkg::NUM_PORTS; p++)
            begin
                if (wr_req[p].we && !full[p])
                begin
                    ref_mem[wr_req[p].addr]     = wr_req[p].data;
                    ref_written[wr_req[p].addr] = 1'b1;
                end
                else if (wr_req[p].we && full[p] && expect_room[p])
                begin
                    drop_errors++;
                    $display("Port %0d lost a write to address 0x%h because its queue was full",
                             p, wr_req[p].addr);
                end
            end
        end
    end

endmodule

//--- tests/tb_banked_sram.sv
`timescale 1ns/1ps

module tb_banked_sram;

    localparam int DRAIN_LIMIT   = 64;
    localparam int STREAM_LEN    = 12;
    localparam int RANDOM_CYCLES = 200;
    localparam int RANDOM_READS  = 32;
    localparam int TEST_CYCLES   = 2 + 2 + 5 * (DRAIN_LIMIT + 6) + STREAM_LEN
                                   + RANDOM_CYCLES + RANDOM_READS;
    localparam int CYCLE_LIMIT   = TEST_CYCLES * 4;

    logic                               clk = 1'b0;
    logic                               reset;
    bank_ram_pkg::wr_req_t              wr_req  [bank_ram_pkg::NUM_PORTS];
    bank_ram_pkg::word_addr_t           rd_addr [bank_ram_pkg::NUM_PORTS];
    bank_ram_pkg::data_t                rd_data [bank_ram_pkg::NUM_PORTS];
    logic [bank_ram_pkg::NUM_PORTS-1:0] full;
    logic                               pending;
    logic [bank_ram_pkg::NUM_PORTS-1:0] expect_room;
    logic                               check_en;

    integer seed;
    int     tb_errors;
    int     cycle_count;
    int     value_errors;
    int     drop_errors;
    int     read_checks;
    int     accepted3;
    logic   saw_full3;
    bank_ram_pkg::word_addr_t twice_addr;

    always #50 clk = ~clk;

    banked_sram uut
    (
        .clk     (clk),
        .reset   (reset),
        .wr_req  (wr_req),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .full    (full),
        .pending (pending)
    );

    sram_checker u_checker
    (
        .clk          (clk),
        .reset        (reset),
        .wr_req       (wr_req),
        .full         (full),
        .expect_room  (expect_room),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .pending      (pending),
        .check_en     (check_en),
        .value_errors (value_errors),
        .drop_errors  (drop_errors),
        .read_checks  (read_checks)
    );

    ////////////////////////////////////////////////////////////
    // Stimulus helpers called at a falling edge
    ////////////////////////////////////////////////////////////

    // Row low bits carry the port number, so ports never share an address
    function automatic bank_ram_pkg::word_addr_t make_addr(input int port, input int idx,
                                                           input int bank);
        return bank_ram_pkg::word_addr_t'((idx << 4) | (port << 2) | bank);
    endfunction

    function automatic bank_ram_pkg::word_addr_t random_read_addr();
        return bank_ram_pkg::word_addr_t'($random(seed) & 32'h7f);
    endfunction

    task automatic set_write(input int port, input bank_ram_pkg::word_addr_t addr,
                             input bank_ram_pkg::data_t data);
        wr_req[port].we   = 1'b1;
        wr_req[port].addr = addr;
        wr_req[port].data = data;
        expect_room[port] = 1'b1;
    endtask

    task automatic idle_writes();
        for (int p = 0; p < bank_ram_pkg::NUM_PORTS; p++)
            wr_req[p].we = 1'b0;
        expect_room = '0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(negedge clk);
        idle_writes();
        while (pending && waited < DRAIN_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (pending)
        begin
            tb_errors++;
            $display("pending stayed high for %0d cycles after the last write", waited);
        end
    endtask

    task automatic read_ports(input bank_ram_pkg::word_addr_t a0,
                              input bank_ram_pkg::word_addr_t a1,
                              input bank_ram_pkg::word_addr_t a2,
                              input bank_ram_pkg::word_addr_t a3);
        rd_addr[0] = a0;
        rd_addr[1] = a1;
        rd_addr[2] = a2;
        rd_addr[3] = a3;
        check_en   = 1'b1;
        @(negedge clk);
        check_en   = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial
    begin
        seed        = 32'h2bd6115b;
        tb_errors   = 0;
        reset       = 1'b1;
        check_en    = 1'b0;
        expect_room = '0;
        for (int p = 0; p < bank_ram_pkg::NUM_PORTS; p++)
        begin
            wr_req[p]  = '0;
            rd_addr[p] = '0;
        end
        repeat (2) @(negedge clk);
        reset = 1'b0;

        // Idle state after reset
        @(negedge clk);
        if (full !== '0)
        begin
            tb_errors++;
            $display("[FAIL] full expected 0x0 actual 0x%h", full);
        end
        if (pending !== 1'b0)
        begin
            tb_errors++;
            $display("[FAIL] pending expected 0x0 actual 0x%h", pending);
        end

        // One write per port into its own bank
        for (int p = 0; p < bank_ram_pkg::NUM_PORTS; p++)
            set_write(p, make_addr(p, 1, p), bank_ram_pkg::data_t'($random(seed)));
        drain();
        read_ports(make_addr(0, 1, 0), make_addr(1, 1, 1), make_addr(2, 1, 2), make_addr(3, 1, 3));

        // All ports hit bank 2 in the same cycle
        for (int p = 0; p < bank_ram_pkg::NUM_PORTS; p++)
            set_write(p, make_addr(p, 5, 2), bank_ram_pkg::data_t'($random(seed)));
        drain();
        read_ports(make_addr(0, 5, 2), make_addr(1, 5, 2), make_addr(2, 5, 2), make_addr(3, 5, 2));

        // Port 0 keeps bank 0 busy while port 3 starves
        accepted3 = 0;
        saw_full3 = 1'b0;
        for (int i = 0; i < STREAM_LEN; i++)
        begin
            @(negedge clk);
            if (full[3])
                saw_full3 = 1'b1;
            else
                accepted3++;
            set_write(0, make_addr(0, 16 + i, 0), bank_ram_pkg::data_t'($random(seed)));
            set_write(3, make_addr(3, 16 + i, 0), bank_ram_pkg::data_t'($random(seed)));
            expect_room[3] = 1'b0;
        end
        drain();
        if (!saw_full3)
        begin
            tb_errors++;
            $display("Port 3 queue never reported full during the bank 0 stream");
        end
        if (accepted3 > bank_ram_pkg::FIFO_DEPTH)
        begin
            tb_errors++;
            $display("Port 3 accepted %0d writes while port 0 held bank 0", accepted3);
        end
        for (int i = 0; i < STREAM_LEN; i += 4)
            read_ports(make_addr(3, 16 + i, 0), make_addr(3, 17 + i, 0),
                       make_addr(3, 18 + i, 0), make_addr(3, 19 + i, 0));

        // Random traffic that never posts into a full queue
        for (int c = 0; c < RANDOM_CYCLES; c++)
        begin
            @(negedge clk);
            idle_writes();
            for (int p = 0; p < bank_ram_pkg::NUM_PORTS; p++)
            begin
                if (!full[p] && ($random(seed) & 1) != 0)
                    set_write(p, make_addr(p, $random(seed) & 7, $random(seed) & 3),
                              bank_ram_pkg::data_t'($random(seed)));
            end
        end
        drain();
        for (int r = 0; r < RANDOM_READS; r++)
            read_ports(random_read_addr(), random_read_addr(), random_read_addr(),
                       random_read_addr());

        // Back-to-back writes to one address from one port
        twice_addr = make_addr(1, 40, 3);
        @(negedge clk);
        set_write(1, twice_addr, 32'h1111_aaaa);
        @(negedge clk);
        set_write(1, twice_addr, 32'h2222_bbbb);
        drain();
        read_ports(twice_addr, twice_addr, twice_addr, twice_addr);

        $display("Read checks %0d, value errors %0d, lost writes %0d, other errors %0d",
                 read_checks, value_errors, drop_errors, tb_errors);
        if (value_errors + drop_errors + tb_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    // Run limit
    initial
    begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule
